// File: src.f
+incdir+tb
design/mem_pkg.sv
design/fetch_unit.sv
design/load_store_unit.sv
design/bus_arbiter.sv
design/data_ram.sv
design/mem_subsystem.sv
tb/mem_subsystem_tb.sv

// File: run.sh
#!/usr/bin/env bash
# build the memory subsystem testbench with Verilator, run it, and check the log
set -e

cd "$(dirname "$0")"

verilator --binary --timing -f src.f --top-module mem_subsystem_tb -o sim_mem

# the log decides the result, so the pipe status is not used
./obj_dir/sim_mem | tee sim.log

if grep -q "TESTBENCH FAILED" sim.log; then
    echo "simulation reported a failure, see sim.log"
    exit 1
fi

echo "simulation finished without failures"

// File: tb/tb_vectors.svh
/* access steps for mem_subsystem_tb, included inside the module body
   stores use op_lb/op_lh/op_lw as SB/SH/SW and always expect zero on ls_rdata
   pc is only used by fetch and both steps, the request only by ls and both steps */

// columns: kind, pc, '{wr, op, byte addr, wdata}, expected instr (fetch) or ls_rdata
localparam int n_steps = 29;

step_t steps [n_steps];

task automatic fill_table();
    steps[0]  = '{k_fetch, 32'h80, '{1'b0, op_lw,  32'h00, 32'h0}, 32'h0}; // never written
    steps[1]  = '{k_ls,    32'h0,  '{1'b1, op_lw,  32'h10, 32'h8c3fa512}, 32'h0};
    steps[2]  = '{k_ls,    32'h0,  '{1'b0, op_lw,  32'h10, 32'h0}, 32'h8c3fa512};
    steps[3]  = '{k_ls,    32'h0,  '{1'b1, op_lw,  32'h20, 32'h11223344}, 32'h0};
    steps[4]  = '{k_ls,    32'h0,  '{1'b1, op_lb,  32'h21, 32'h123456ab}, 32'h0}; // SB lane 1
    steps[5]  = '{k_ls,    32'h0,  '{1'b1, op_lb,  32'h23, 32'h000000cd}, 32'h0}; // SB lane 3
    steps[6]  = '{k_ls,    32'h0,  '{1'b0, op_lw,  32'h20, 32'h0}, 32'hcd22ab44};
    steps[7]  = '{k_ls,    32'h0,  '{1'b1, op_lh,  32'h22, 32'haaaa5566}, 32'h0}; // upper half
    steps[8]  = '{k_ls,    32'h0,  '{1'b0, op_lw,  32'h20, 32'h0}, 32'h5566ab44};
    steps[9]  = '{k_ls,    32'h0,  '{1'b1, op_lh,  32'h20, 32'h00007788}, 32'h0}; // lower half
    steps[10] = '{k_ls,    32'h0,  '{1'b1, op_lb,  32'h22, 32'h00000099}, 32'h0};
    steps[11] = '{k_ls,    32'h0,  '{1'b1, op_lb,  32'h20, 32'h123456ee}, 32'h0}; // SB lane 0
    steps[12] = '{k_ls,    32'h0,  '{1'b0, op_lw,  32'h20, 32'h0}, 32'h559977ee};
    steps[13] = '{k_ls,    32'h0,  '{1'b1, op_lw,  32'h30, 32'h80f17e92}, 32'h0};
    steps[14] = '{k_ls,    32'h0,  '{1'b0, op_lb,  32'h30, 32'h0}, 32'hffffff92}; // sign set
    steps[15] = '{k_ls,    32'h0,  '{1'b0, op_lb,  32'h31, 32'h0}, 32'h0000007e};
    steps[16] = '{k_ls,    32'h0,  '{1'b0, op_lb,  32'h32, 32'h0}, 32'hfffffff1};
    steps[17] = '{k_ls,    32'h0,  '{1'b0, op_lbu, 32'h32, 32'h0}, 32'h000000f1};
    steps[18] = '{k_ls,    32'h0,  '{1'b0, op_lbu, 32'h30, 32'h0}, 32'h00000092};
    steps[19] = '{k_ls,    32'h0,  '{1'b0, op_lh,  32'h30, 32'h0}, 32'h00007e92};
    steps[20] = '{k_ls,    32'h0,  '{1'b0, op_lh,  32'h32, 32'h0}, 32'hffff80f1};
    steps[21] = '{k_ls,    32'h0,  '{1'b0, op_lhu, 32'h32, 32'h0}, 32'h000080f1};
    steps[22] = '{k_fetch, 32'h10, '{1'b0, op_lw,  32'h00, 32'h0}, 32'h8c3fa512}; // SW'd word
    steps[23] = '{k_both,  32'h30, '{1'b0, op_lw,  32'h20, 32'h0}, 32'h559977ee};
    steps[24] = '{k_both,  32'h10, '{1'b0, op_lbu, 32'h23, 32'h0}, 32'h00000055};
    steps[25] = '{k_ls,    32'h0,  '{1'b1, op_lw,  32'h400, 32'hdeadbeef}, 32'h0}; // word 256
    steps[26] = '{k_ls,    32'h0,  '{1'b0, op_lw,  32'h410, 32'h0}, 32'h0}; // would alias word 4
    steps[27] = '{k_ls,    32'h0,  '{1'b0, op_lw,  32'h000, 32'h0}, 32'h0}; // no wrap to word 0
    steps[28] = '{k_fetch, 32'h430, '{1'b0, op_lw, 32'h00, 32'h0}, 32'h0}; // would alias word 12
endtask

// File: tb/mem_subsystem_tb.sv
/* table driven testbench for mem_subsystem with a word array reference model
   the model assumes ram_depth 256 (byte addresses below 32'h400 are in range)
   stops at the first mismatch; a cycle counter bounds the whole run */
`timescale 1ns/1ns

module mem_subsystem_tb;
    import mem_pkg::*;

    typedef enum logic [1:0] {k_fetch, k_ls, k_both} step_kind_t;

    typedef struct packed {
        step_kind_t   kind;
        logic [31:0]  pc;
        core_ls_req_t req;
        logic [31:0]  exp_val; // instr for fetch steps, ls_rdata otherwise
    } step_t;

    `include "tb_vectors.svh"

    localparam int          n_rand_pairs = 40;  // random store/load pairs
    localparam int          cycle_limit  = (n_steps + 2 * n_rand_pairs) * 20 + 4;
    localparam logic [31:0] ram_bytes    = 32'h400; // 256 words

    logic         clk = 1'b0;
    logic         nrst;
    logic         fetch_req, ls_req;
    logic [31:0]  pc;
    core_ls_req_t ls_req_bits;
    logic         fetch_ack, ls_ack, freeze;
    logic [31:0]  instr, ls_rdata;
    logic [31:0]  model_mem [256] = '{default: '0};
    int           cycles = 0;

    mem_subsystem #(.ram_depth(256)) dut0 (
        .clk(clk), .nrst(nrst),
        .fetch_req(fetch_req), .pc(pc), .fetch_ack(fetch_ack), .instr(instr),
        .ls_req(ls_req), .ls_req_bits(ls_req_bits), .ls_ack(ls_ack), .ls_rdata(ls_rdata),
        .freeze(freeze)
    );

    always #50 clk = ~clk; // 100 ns period

    task automatic abort_run();
        $display("TESTBENCH FAILED");
        $fatal(1, "simulation stopped after a failure");
    endtask

    task automatic check_word(input string what, input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp) begin
            $display("** Error @ %0t ns: %s expected %h, got %h", $time, what, exp, act);
            abort_run();
        end
    endtask

    task automatic check_flag(input string what, input logic exp, input logic act);
        if (act !== exp) begin
            $display("** Error @ %0t ns: %s expected %b, got %b", $time, what, exp, act);
            abort_run();
        end
    endtask

    // whole word at a byte address, zero past the end
    function automatic logic [31:0] model_read(input logic [31:0] addr);
        if (addr < ram_bytes)
            return model_mem[addr[9:2]];
        return 32'h0;
    endfunction

    function automatic logic [31:0] model_load(input core_ls_req_t r);
        logic [31:0] w, b, h;
        w = model_read(r.addr);
        b = (w >> {r.addr[1:0], 3'b000}) & 32'hff;   // byte lane
        h = (w >> {r.addr[1], 4'b0000}) & 32'hffff;  // half lane
        case (r.op)
            op_lb:   return b[7] ? (b | 32'hffffff00) : b;
            op_lh:   return h[15] ? (h | 32'hffff0000) : h;
            op_lbu:  return b;
            op_lhu:  return h;
            default: return w;
        endcase
    endfunction

    function automatic void model_store(input core_ls_req_t r);
        logic [31:0] mask, data;
        case (r.op)
            op_lb: begin
                mask = 32'hff << {r.addr[1:0], 3'b000};
                data = (r.wdata & 32'hff) << {r.addr[1:0], 3'b000};
            end
            op_lh: begin
                mask = 32'hffff << {r.addr[1], 4'b0000};
                data = (r.wdata & 32'hffff) << {r.addr[1], 4'b0000};
            end
            default: begin
                mask = 32'hffffffff;
                data = r.wdata;
            end
        endcase
        if (r.addr < ram_bytes) // out of range stores dropped
            model_mem[r.addr[9:2]] = (model_mem[r.addr[9:2]] & ~mask) | (data & mask);
    endfunction

    // one four-phase round on one or both core ports
    task automatic run_access(input step_kind_t kind, input logic [31:0] pc_v,
                              input core_ls_req_t req_v, input logic [31:0] exp_instr,
                              input logic [31:0] exp_ls);
        logic f_pend, l_pend;
        f_pend = (kind != k_ls);
        l_pend = (kind != k_fetch);
        @(posedge clk);
        pc          <= pc_v;
        ls_req_bits <= req_v;
        fetch_req   <= f_pend;
        ls_req      <= l_pend;
        while (f_pend || l_pend) begin
            @(negedge clk);
            check_flag("freeze while pending", 1'b1, freeze);
            if (f_pend && fetch_ack) begin
                check_word("instr", exp_instr, instr);
                f_pend = 1'b0;
            end
            if (l_pend && ls_ack) begin
                check_word("ls_rdata", exp_ls, ls_rdata);
                l_pend = 1'b0;
            end
            @(posedge clk);
            if (!f_pend) fetch_req <= 1'b0; // drop req as soon as ack seen
            if (!l_pend) ls_req <= 1'b0;
        end
        @(negedge clk);
        while (fetch_ack || ls_ack) begin
            check_flag("freeze until acks fall", 1'b1, freeze);
            @(negedge clk);
        end
        check_flag("freeze after handshake", 1'b0, freeze);
    endtask

    // run bound
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("timeout: handshakes did not finish within %0d cycles", cycle_limit);
            abort_run();
        end
    end

    initial begin
        logic [31:0]  exp_instr, exp_ls, exp_tab;
        core_ls_req_t st, ld;
        int           r;
        void'($urandom(94));
        nrst        = 1'b0;
        fetch_req   = 1'b0;
        ls_req      = 1'b0;
        pc          = '0;
        ls_req_bits = '0;
        fill_table();
        repeat (2) @(posedge clk);
        nrst <= 1'b1;
        @(negedge clk);
        check_flag("freeze after reset", 1'b0, freeze);
        check_flag("fetch_ack after reset", 1'b0, fetch_ack);
        check_flag("ls_ack after reset", 1'b0, ls_ack);

        for (int i = 0; i < n_steps; i++) begin
            exp_instr = model_read(steps[i].pc);
            exp_ls    = steps[i].req.wr ? 32'h0 : model_load(steps[i].req);
            exp_tab   = (steps[i].kind == k_fetch) ? exp_instr : exp_ls;
            if (exp_tab !== steps[i].exp_val) begin
                $display("table step %0d expects %h but the reference model gives %h",
                         i, steps[i].exp_val, exp_tab);
                abort_run();
            end
            run_access(steps[i].kind, steps[i].pc, steps[i].req, exp_instr, exp_ls);
            if (steps[i].kind != k_fetch && steps[i].req.wr)
                model_store(steps[i].req);
        end

        // random store then load at the same spot, some past the end
        for (int k = 0; k < n_rand_pairs; k++) begin
            st.wr    = 1'b1;
            st.addr  = $urandom % 1200;
            st.wdata = $urandom;
            r        = $urandom % 3;
            case (r)
                0:       st.op = op_lb;
                1: begin
                    st.op      = op_lh;
                    st.addr[0] = 1'b0;
                end
                default: begin
                    st.op        = op_lw;
                    st.addr[1:0] = 2'b00;
                end
            endcase
            run_access(k_ls, 32'h0, st, 32'h0, 32'h0);
            model_store(st);
            ld       = st;
            ld.wr    = 1'b0;
            ld.wdata = '0;
            r        = $urandom % 5;
            case (r)
                0:       ld.op = op_lb;
                1: begin
                    ld.op      = op_lh;
                    ld.addr[0] = 1'b0;
                end
                2: begin
                    ld.op        = op_lw;
                    ld.addr[1:0] = 2'b00;
                end
                3:       ld.op = op_lbu;
                default: begin
                    ld.op      = op_lhu;
                    ld.addr[0] = 1'b0;
                end
            endcase
            run_access(k_ls, 32'h0, ld, 32'h0, model_load(ld));
        end

        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

// File: design/mem_subsystem.sv
/* memory access path: fetch and load/store units sharing one RAM
   core side follows a four-phase req/ack handshake on both ports
   freeze is high from any core req until its ack falls */
`timescale 1ns/1ns

module mem_subsystem #(
    parameter int ram_depth = 256
) (
    input  logic                  clk,
    input  logic                  nrst,
    input  logic                  fetch_req,
    input  logic [31:0]           pc,
    output logic                  fetch_ack,
    output logic [31:0]           instr,
    input  logic                  ls_req,
    input  mem_pkg::core_ls_req_t ls_req_bits,
    output logic                  ls_ack,
    output logic [31:0]           ls_rdata,
    output logic                  freeze
);
    import mem_pkg::*;

    logic     if_bus_req, if_bus_ack;
    bus_req_t if_bus_out;
    bus_rsp_t if_bus_rsp;
    logic     ls_bus_req, ls_bus_ack;
    bus_req_t ls_bus_out;
    bus_rsp_t ls_bus_rsp;
    logic     ram_en;
    bus_req_t ram_req;
    bus_rsp_t ram_rsp;

    fetch_unit fetch0 (
        .clk(clk), .nrst(nrst),
        .fetch_req(fetch_req), .pc(pc), .fetch_ack(fetch_ack), .instr(instr),
        .bus_req(if_bus_req), .bus_out(if_bus_out),
        .bus_ack(if_bus_ack), .bus_in(if_bus_rsp)
    );

    load_store_unit lsu0 (
        .clk(clk), .nrst(nrst),
        .ls_req(ls_req), .ls_req_bits(ls_req_bits), .ls_ack(ls_ack), .ls_rdata(ls_rdata),
        .bus_req(ls_bus_req), .bus_out(ls_bus_out),
        .bus_ack(ls_bus_ack), .bus_in(ls_bus_rsp)
    );

    bus_arbiter arb0 (
        .clk(clk), .nrst(nrst),
        .ls_bus_req(ls_bus_req), .ls_bus_in(ls_bus_out),
        .ls_bus_ack(ls_bus_ack), .ls_bus_rsp(ls_bus_rsp),
        .if_bus_req(if_bus_req), .if_bus_in(if_bus_out),
        .if_bus_ack(if_bus_ack), .if_bus_rsp(if_bus_rsp),
        .ram_en(ram_en), .ram_req(ram_req), .ram_rsp(ram_rsp)
    );

    data_ram #(.ram_depth(ram_depth)) ram0 (
        .clk(clk), .nrst(nrst),
        .ram_en(ram_en), .ram_req(ram_req), .ram_rsp(ram_rsp)
    );

    // core stalls while any access is in flight
    assign freeze = fetch_req | ls_req | fetch_ack | ls_ack;

endmodule

// File: design/data_ram.sv
/* single port word RAM with byte enables and a registered read
   word addresses at or beyond ram_depth read zero and drop writes
   contents start at zero; nrst clears only the read register */
`timescale 1ns/1ns

module data_ram #(
    parameter int ram_depth = 256
) (
    input  logic              clk,
    input  logic              nrst,
    input  logic              ram_en,
    input  mem_pkg::bus_req_t ram_req,
    output mem_pkg::bus_rsp_t ram_rsp
);
    import mem_pkg::*;

    localparam int aw = (ram_depth > 1) ? $clog2(ram_depth) : 1;

    mem_word_u       mem [ram_depth] = '{default: '0};
    mem_word_u       wd;       // write data by lane
    logic            in_range;
    logic [aw-1:0]   idx;

    assign in_range = (ram_req.waddr < ram_depth);
    assign idx      = ram_req.waddr[aw-1:0];
    assign wd.word  = ram_req.wdata;

    // byte merge under be
    always_ff @(posedge clk) begin
        if (ram_en && ram_req.wr && in_range) begin
            for (int b = 0; b < 4; b++) begin
                if (ram_req.be[b])
                    mem[idx].lane[b] <= wd.lane[b];
            end
        end
    end

    // read before write on a store cycle
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst)
            ram_rsp <= '0;
        else if (ram_en)
            ram_rsp.rdata <= in_range ? mem[idx].word : 32'b0;
    end

endmodule

// File: design/bus_arbiter.sv
/* fixed priority for the single ram port: data wins over fetch
   a requester that keeps req high keeps the port; requesters must drop req promptly
   latency is 2 cycles from req to ack when the port is free */
`timescale 1ns/1ns

module bus_arbiter (
    input  logic              clk,
    input  logic              nrst,
    input  logic              ls_bus_req,
    input  mem_pkg::bus_req_t ls_bus_in,
    output logic              ls_bus_ack,
    output mem_pkg::bus_rsp_t ls_bus_rsp,
    input  logic              if_bus_req,
    input  mem_pkg::bus_req_t if_bus_in,
    output logic              if_bus_ack,
    output mem_pkg::bus_rsp_t if_bus_rsp,
    output logic              ram_en,
    output mem_pkg::bus_req_t ram_req,
    input  mem_pkg::bus_rsp_t ram_rsp
);
    import mem_pkg::*;

    typedef enum logic [1:0] {
        arb_idle,   // port free
        arb_access, // ram cycle
        arb_ack     // ack to owner until its req falls
    } arb_state_t;

    arb_state_t state;
    logic       owner_if;  // 1 = fetch owns the port
    logic       owner_req;
    bus_req_t   req_q;     // latched winner request

    assign owner_req = owner_if ? if_bus_req : ls_bus_req;

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            state    <= arb_idle;
            owner_if <= 1'b0;
        end else begin
            case (state)
                arb_idle: begin
                    if (ls_bus_req) begin // data first
                        owner_if <= 1'b0;
                        state    <= arb_access;
                    end else if (if_bus_req) begin
                        owner_if <= 1'b1;
                        state    <= arb_access;
                    end
                end
                arb_access: state <= arb_ack;
                arb_ack:    if (!owner_req) state <= arb_idle; // return to zero
                default:    state <= arb_idle;
            endcase
        end
    end

    // payload latch, same priority as the grant
    always_ff @(posedge clk) begin
        if (state == arb_idle)
            req_q <= ls_bus_req ? ls_bus_in : if_bus_in;
    end

    assign ram_en  = (state == arb_access); // one pulse per grant
    assign ram_req = req_q;

    assign ls_bus_ack = (state == arb_ack) && !owner_if;
    assign if_bus_ack = (state == arb_ack) && owner_if;

    // ram output register holds the word until the next ram_en
    assign ls_bus_rsp = owner_if ? '0 : ram_rsp;
    assign if_bus_rsp = owner_if ? ram_rsp : '0;

endmodule

// File: design/load_store_unit.sv
/* data side of the core: SB/SH/SW stores and LB/LH/LW/LBU/LHU loads
   misaligned addresses are not trapped; a half-word uses addr[1], a word ignores addr[1:0]
   ls_req_bits must stay stable while ls_req is high; ls_rdata reads zero after a store */
`timescale 1ns/1ns

module load_store_unit (
    input  logic                  clk,
    input  logic                  nrst,
    input  logic                  ls_req,
    input  mem_pkg::core_ls_req_t ls_req_bits,
    output logic                  ls_ack,
    output logic [31:0]           ls_rdata,
    output logic                  bus_req,
    output mem_pkg::bus_req_t     bus_out,
    input  logic                  bus_ack,
    input  mem_pkg::bus_rsp_t     bus_in
);
    import mem_pkg::*;

    typedef enum logic [1:0] {
        st_idle,
        st_bus_req,
        st_bus_rel,
        st_core_ack
    } ls_state_t;

    ls_state_t state, state_nxt;

    mem_word_u  raw_q;    // word as read from the bus
    mem_word_u  st_word;  // store data moved to its lanes
    logic [3:0] st_be;
    logic [1:0] lsel;     // byte lane from the address
    logic [7:0] byte_sel;
    logic [15:0] half_sel;
    logic [31:0] load_val;

    assign lsel = ls_req_bits.addr[1:0];

    // store lane placement
    always_comb begin
        st_word.word = '0;
        st_be        = 4'b0000;
        case (ls_req_bits.op)
            op_lb: begin // SB
                st_word.lane[lsel] = ls_req_bits.wdata[7:0];
                st_be[lsel]        = 1'b1;
            end
            op_lh: begin // SH, lower or upper half
                st_word.lane[{lsel[1], 1'b0}] = ls_req_bits.wdata[7:0];
                st_word.lane[{lsel[1], 1'b1}] = ls_req_bits.wdata[15:8];
                st_be[{lsel[1], 1'b0}]        = 1'b1;
                st_be[{lsel[1], 1'b1}]        = 1'b1;
            end
            default: begin // SW
                st_word.word = ls_req_bits.wdata;
                st_be        = 4'hf;
            end
        endcase
    end

    always_comb begin
        bus_out.wr    = ls_req_bits.wr;
        bus_out.be    = ls_req_bits.wr ? st_be : 4'hf; // loads read all lanes
        bus_out.waddr = {2'b00, ls_req_bits.addr[31:2]};
        bus_out.wdata = ls_req_bits.wr ? st_word.word : '0;
    end

    // load lane pick and extension
    always_comb begin
        byte_sel = raw_q.lane[lsel];
        half_sel = {raw_q.lane[{lsel[1], 1'b1}], raw_q.lane[{lsel[1], 1'b0}]};
        case (ls_req_bits.op)
            op_lb:   load_val = {{24{byte_sel[7]}}, byte_sel};
            op_lh:   load_val = {{16{half_sel[15]}}, half_sel};
            op_lbu:  load_val = {24'b0, byte_sel};
            op_lhu:  load_val = {16'b0, half_sel};
            default: load_val = raw_q.word; // LW
        endcase
    end

    always_comb begin
        state_nxt = state;
        case (state)
            st_idle:     if (ls_req) state_nxt = st_bus_req;
            st_bus_req:  if (bus_ack) state_nxt = st_bus_rel;
            st_bus_rel:  if (!bus_ack) state_nxt = st_core_ack;
            st_core_ack: if (!ls_req) state_nxt = st_idle;
            default:     state_nxt = st_idle;
        endcase
    end

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            state    <= st_idle;
            ls_rdata <= '0;
        end else begin
            state <= state_nxt;
            // result registered as ls_ack rises
            if (state == st_bus_rel && !bus_ack)
                ls_rdata <= ls_req_bits.wr ? 32'b0 : load_val;
        end
    end

    always_ff @(posedge clk) begin
        if (state == st_bus_req && bus_ack)
            raw_q.word <= bus_in.rdata; // arbiter holds rsp while ack is high
    end

    assign bus_req = (state == st_bus_req);
    assign ls_ack  = (state == st_core_ack);

endmodule

// File: design/fetch_unit.sv
/* instruction fetch over the shared ram bus
   pc is a byte address; the low two bits are dropped, no misaligned trap
   pc must stay stable while fetch_req is high */
`timescale 1ns/1ns

module fetch_unit (
    input  logic              clk,
    input  logic              nrst,
    input  logic              fetch_req,
    input  logic [31:0]       pc,
    output logic              fetch_ack,
    output logic [31:0]       instr,
    output logic              bus_req,
    output mem_pkg::bus_req_t bus_out,
    input  logic              bus_ack,
    input  mem_pkg::bus_rsp_t bus_in
);

    typedef enum logic [1:0] {
        st_idle,     // waiting for the core
        st_bus_req,  // bus req high
        st_bus_rel,  // bus req dropped, wait for bus ack low
        st_core_ack  // fetch_ack high until core drops req
    } fetch_state_t;

    fetch_state_t state, state_nxt;

    always_comb begin
        state_nxt = state;
        case (state)
            st_idle:     if (fetch_req) state_nxt = st_bus_req;
            st_bus_req:  if (bus_ack) state_nxt = st_bus_rel;
            st_bus_rel:  if (!bus_ack) state_nxt = st_core_ack; // bus back to zero
            st_core_ack: if (!fetch_req) state_nxt = st_idle;
            default:     state_nxt = st_idle;
        endcase
    end

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            state <= st_idle;
            instr <= '0;
        end else begin
            state <= state_nxt;
            if (state == st_bus_req && bus_ack)
                instr <= bus_in.rdata; // held until the next fetch
        end
    end

    assign bus_req   = (state == st_bus_req);
    assign fetch_ack = (state == st_core_ack);

    // read only, whole word
    always_comb begin
        bus_out.wr    = 1'b0;
        bus_out.be    = 4'hf;
        bus_out.waddr = {2'b00, pc[31:2]};
        bus_out.wdata = '0;
    end

endmodule

// File: design/mem_pkg.sv
/* shared types of the memory access path
   stores reuse the func3 codes of LB/LH/LW (SB=0, SH=1, SW=2); the write flag
   tells a store from a load. Byte addresses on the core side, word addresses on the bus */
package mem_pkg;

    // access size and sign, RV32 func3 encoding
    typedef enum logic [2:0] {
        op_lb  = 3'b000, // also SB
        op_lh  = 3'b001, // also SH
        op_lw  = 3'b010, // also SW
        op_lbu = 3'b100,
        op_lhu = 3'b101
    } ls_op_t;

    // one ram word, seen whole or as byte lanes
    // lane 0 is bits 7:0 (little endian)
    typedef union packed {
        logic [31:0]     word;
        logic [3:0][7:0] lane;
    } mem_word_u;

    // core data request, stable while ls_req is high
    typedef struct packed {
        logic        wr;    // 1 = store
        ls_op_t      op;    // size and sign
        logic [31:0] addr;  // byte address
        logic [31:0] wdata; // store data, low bits used for SB/SH
    } core_ls_req_t;

    // request on the shared ram bus
    typedef struct packed {
        logic        wr;
        logic [3:0]  be;    // byte enables, writes only
        logic [31:0] waddr; // word address
        logic [31:0] wdata; // already placed in its lanes
    } bus_req_t;

    // response on the shared ram bus
    typedef struct packed {
        logic [31:0] rdata; // whole word
    } bus_rsp_t;

endpackage
